// ==== tests/t08_core_stimulus.txt ====
# columns: command, APB byte address (hex), value (hex); W writes, R reads and compares
# S starts the core and polls status until halted; 400 is control, 404 is status
W 000 FF900093
W 004 00500113
W 008 002081B3
W 00C 40208233
W 010 0020F2B3
W 014 0020E333
W 018 0020C3B3
W 01C 0020A433
W 020 001124B3
W 024 20302023
W 028 20402223
W 02C 20502423
W 030 20602623
W 034 20702823
W 038 20802A23
W 03C 20902C23
W 040 30002503
W 044 002505B3
W 048 20B02E23
W 04C 06300013
W 050 22002023
W 054 00500613
W 058 00000693
W 05C FFF60613
W 060 00168693
W 064 00060463
W 068 FE000AE3
W 06C 22C02223
W 070 22D02423
W 074 0080076F
W 078 00100793
W 07C 22E02623
W 080 22F02823
W 084 00000073
# data words: LW source, and words the program must overwrite with zero
W 300 12345678
W 220 DEADBEEF
W 230 0BADF00D
R 000 FF900093
R 068 FE000AE3
R 084 00000073
R 300 12345678
R 404 00000000
S
R 200 FFFFFFFE
R 204 FFFFFFF4
R 208 00000001
R 20C FFFFFFFD
R 210 FFFFFFFC
R 214 00000001
R 218 00000000
R 21C 1234567D
R 220 00000000
R 224 00000000
R 228 00000005
R 22C 00000078
R 230 00000000
# second run: clear two results, start without polling, read while running
W 228 00000000
W 21C 00000000
W 400 00000001
R 404 00000001
R 228 00000005
R 404 00000002
R 21C 1234567D
R 22C 00000078
R 200 FFFFFFFE

// ==== t08_core.f ====
src/t08_pkg.sv
src/t08_registers.sv
src/t08_alu.sv
src/t08_program_counter.sv
src/t08_control_fsm.sv
src/t08_memory.sv
src/t08_core.sv
tests/t08_core_checker.sv
tests/t08_core_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := t08_core_tb
FILELIST := t08_core.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD)

// ==== tests/t08_core_tb.sv ====
`default_nettype none

module t08_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import t08_pkg::*;

    localparam int ready_timeout = 2000; // Cycles an access may stall
    localparam int poll_limit = 500;     // Status reads before giving up

    logic clk, nRst;
    logic [11:0] paddr;
    logic psel, penable, pwrite;
    logic [xlen-1:0] pwdata, prdata;
    logic pready, pslverr;
    int error_count;

    t08_core t08_core_i (
        .clk, .nRst,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic compare_data(input logic [xlen-1:0] actual, expected,
                                input logic [11:0] addr);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("FAILED at %0d ns: read of %h gave %h, expected %h",
                                $time, addr, actual, expected));
        end
    endtask

    task automatic compare_status(input logic [1:0] actual, expected);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("FAILED at %0d ns: status {halted, running} is %b, expected %b",
                                $time, actual, expected));
        end
    endtask

    // One APB transfer, sampled a quarter period before the rising edge
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #25;
        while (!pready) begin // Wait states while the core owns memory
            @(negedge clk);
            #25;
            cycles++;
            if (cycles > ready_timeout) begin
                abort_run($sformatf("Timeout: pready never came for the access to address %h",
                                    addr));
            end
        end
        rdata = prdata;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [xlen-1:0] rdata, expected);
        if (addr == addr_status) begin
            compare_status(rdata[1:0], expected[1:0]);
        end else begin
            compare_data(rdata, expected, addr);
        end
    endtask

    task automatic run_program();
        logic [xlen-1:0] rdata;
        int polls;
        polls = 0;
        apb_access(1'b1, addr_ctrl, xlen'(1), rdata);
        apb_access(1'b0, addr_status, '0, rdata);
        while (!rdata[1]) begin // Until halted
            polls++;
            if (polls > poll_limit) begin
                abort_run("Timeout: the core did not halt after start");
            end
            apb_access(1'b0, addr_status, '0, rdata);
        end
        compare_status(rdata[1:0], 2'b10);
    endtask

    task automatic read_args(input int fd, output logic [11:0] addr,
                             output logic [xlen-1:0] value);
        int code;
        code = $fscanf(fd, "%h %h", addr, value);
        if (code != 2) begin
            abort_run("Malformed W or R line in the stimulus file");
        end
    endtask

    initial begin
        int fd;
        int code;
        logic [7:0] cmd;
        logic [11:0] addr;
        logic [xlen-1:0] value, rdata;
        logic [8*120-1:0] line;
        bit done;
        error_count = 0;
        nRst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (10) @(negedge clk);
        nRst = 1'b1;
        fd = $fopen("tests/t08_core_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file tests/t08_core_stimulus.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1; // End of file
            end else begin
                case (cmd)
                    "#": code = $fgets(line, fd);
                    "W": begin
                        read_args(fd, addr, value);
                        apb_access(1'b1, addr, value, rdata);
                    end
                    "R": begin
                        read_args(fd, addr, value);
                        apb_access(1'b0, addr, '0, rdata);
                        check_read(addr, rdata, value);
                    end
                    "S": run_program();
                    default: abort_run($sformatf("Unknown command %c in the stimulus file", cmd));
                endcase
            end
        end
        $fclose(fd);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("Mismatches were counted during the run");
        end
    end

endmodule

`default_nettype wire

// ==== tests/t08_core_checker.sv ====
`default_nettype none

module t08_core_checker (
    input  logic clk, nRst,
    input  logic [11:0] paddr,
    input  logic psel, penable, pready, pslverr,
    input  logic [t08_pkg::xlen-1:0] x0, // Register file entry 0
    input  logic [t08_pkg::xlen-1:0] pc
);
    timeunit 1ns;
    timeprecision 1ps;
    import t08_pkg::*;

    assert property (@(posedge clk) disable iff (!nRst) !pslverr)
        else $error("pslverr went high");

    // Control and status never take wait states
    assert property (@(posedge clk) disable iff (!nRst)
        (psel && penable && (paddr == addr_ctrl || paddr == addr_status)) |-> pready)
        else $error("Control or status access was held off");

    assert property (@(posedge clk) disable iff (!nRst) x0 == '0)
        else $error("Register x0 holds a non-zero value");

    assert property (@(posedge clk) disable iff (!nRst) pc[1:0] == 2'b00)
        else $error("PC is not word aligned");

endmodule

bind t08_core t08_core_checker checker_i (
    .clk, .nRst, .paddr, .psel, .penable, .pready, .pslverr,
    .x0(registers_i.data[0]),
    .pc
);

`default_nettype wire

// ==== src/t08_core.sv ====
`default_nettype none

module t08_core (
    input  logic clk, nRst,
    input  logic [11:0] paddr,
    input  logic psel, penable, pwrite,
    input  logic [t08_pkg::xlen-1:0] pwdata,
    output logic [t08_pkg::xlen-1:0] prdata,
    output logic pready, pslverr
);
    import t08_pkg::*;

    logic [xlen-1:0] pc, pc_next_seq, imm;
    logic [xlen-1:0] reg_r1, reg_r2, alu_result, mem_rdata;
    logic [4:0] address_r1, address_r2, address_rd;
    logic [2:0] alu_op;
    logic [1:0] wb_sel;
    logic en_read_1, en_read_2, en_write, alu_use_imm, alu_zero;
    logic mem_read, mem_write, mem_sel_alu;
    logic pc_step, pc_branch, pc_jump, running, halt, start;

    t08_registers registers_i (
        .clk, .nRst,
        .address_r1, .address_r2, .address_rd,
        .data_in_frommemory(mem_rdata),
        .data_in_frominstructionfetch(pc_next_seq),
        .data_in_fromalu(alu_result),
        .data_in_control(wb_sel),
        .en_read_1, .en_read_2, .en_write,
        .data_out_r1(reg_r1),
        .data_out_r2(reg_r2)
    );

    t08_alu alu_i (
        .operand_a(reg_r1),
        .operand_b(alu_use_imm ? imm : reg_r2),
        .alu_op,
        .alu_result,
        .zero(alu_zero)
    );

    t08_program_counter program_counter_i (
        .clk, .nRst, .start,
        .pc_step, .pc_branch, .pc_jump,
        .offset(imm),
        .pc, .pc_next_seq
    );

    t08_control_fsm control_fsm_i (
        .clk, .nRst, .start, .mem_rdata, .alu_zero,
        .mem_read, .mem_write, .mem_sel_alu,
        .address_r1, .address_r2, .address_rd,
        .en_read_1, .en_read_2, .en_write, .wb_sel,
        .alu_op, .alu_use_imm, .imm,
        .pc_step, .pc_branch, .pc_jump,
        .running, .halt
    );

    t08_memory memory_i (
        .clk, .nRst,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .running, .halt, .start,
        .mem_addr(mem_sel_alu ? alu_result : pc), // Data address or fetch address
        .mem_wdata(reg_r2),
        .mem_read, .mem_write, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== src/t08_memory.sv ====
`default_nettype none

module t08_memory (
    input  logic clk, nRst,
    input  logic [11:0] paddr,
    input  logic psel, penable, pwrite,
    input  logic [t08_pkg::xlen-1:0] pwdata,
    output logic [t08_pkg::xlen-1:0] prdata,
    output logic pready, pslverr,
    input  logic running, halt,
    output logic start,
    input  logic [t08_pkg::xlen-1:0] mem_addr, mem_wdata,
    input  logic mem_read, mem_write,
    output logic [t08_pkg::xlen-1:0] mem_rdata
);
    import t08_pkg::*;

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0] word_addr;
    logic [xlen-1:0] wr_data;
    logic is_mem, apb_ok, halted, rd_en, wr_en;

    assign is_mem = (paddr < addr_ctrl);
    assign pready = penable && (!is_mem || apb_ok); // Memory waits for a read done with the core idle
    assign pslverr = 1'b0;
    assign start = psel && penable && pwrite && (paddr == addr_ctrl) && pwdata[0] && !running;

    // One port, owned by the core while it runs
    assign word_addr = running ? mem_addr[aw+1:2] : paddr[aw+1:2];
    assign wr_data = running ? mem_wdata : pwdata;
    assign rd_en = running ? mem_read : (psel && is_mem);
    assign wr_en = running ? mem_write : (psel && penable && pwrite && is_mem && apb_ok);

    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_rdata <= mem[word_addr];
        end
        if (wr_en) begin
            mem[word_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            apb_ok <= 1'b0;
            halted <= 1'b0;
        end else begin
            apb_ok <= psel && is_mem && !running && !(penable && pready);
            if (start) begin
                halted <= 1'b0;
            end else if (halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_comb begin
        if (is_mem) begin
            prdata = mem_rdata;
        end else if (paddr == addr_status) begin
            prdata = {{(xlen-2){1'b0}}, halted, running};
        end else if (paddr == addr_ctrl) begin
            prdata = {{(xlen-1){1'b0}}, running};
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/t08_control_fsm.sv ====
`default_nettype none

module t08_control_fsm (
    input  logic clk, nRst,
    input  logic start,
    input  logic [t08_pkg::xlen-1:0] mem_rdata,
    input  logic alu_zero,
    output logic mem_read, mem_write, mem_sel_alu,
    output logic [4:0] address_r1, address_r2, address_rd,
    output logic en_read_1, en_read_2, en_write,
    output logic [1:0] wb_sel,
    output logic [2:0] alu_op,
    output logic alu_use_imm,
    output logic [t08_pkg::xlen-1:0] imm,
    output logic pc_step, pc_branch, pc_jump,
    output logic running, halt
);
    import t08_pkg::*;

    logic [2:0] state, state_next;
    t08_instr_t instr_q, instr_cur;
    logic [6:0] opcode;

    // Register reads in decode take their addresses straight from the fetched word
    assign instr_cur = (state == st_decode) ? mem_rdata : instr_q;
    assign opcode = instr_q.r.opcode;

    assign address_r1 = instr_cur.r.rs1;
    assign address_r2 = instr_cur.r.rs2;
    assign address_rd = instr_q.r.rd;
    assign en_read_1 = (state == st_decode);
    assign en_read_2 = (state == st_decode);

    assign alu_use_imm = (opcode == op_itype) || (opcode == op_load) || (opcode == op_store);

    always_comb begin
        case (opcode)
            op_store: imm = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
            op_branch: imm = {{19{instr_q.b.imm12}}, instr_q.b.imm12, instr_q.b.imm11,
                              instr_q.b.imm10_5, instr_q.b.imm4_1, 1'b0};
            op_jal: imm = {{11{instr_q.j.imm20}}, instr_q.j.imm20, instr_q.j.imm19_12,
                           instr_q.j.imm11, instr_q.j.imm10_1, 1'b0};
            default: imm = {{20{instr_q.i.imm[11]}}, instr_q.i.imm}; // I format
        endcase
    end

    always_comb begin
        alu_op = alu_add; // Address and ADDI arithmetic
        if (opcode == op_branch) begin
            alu_op = alu_sub;
        end else if (opcode == op_rtype || opcode == op_itype) begin
            case (instr_q.r.funct3)
                f3_add_sub: begin
                    if (opcode == op_rtype && instr_q.r.funct7 == f7_sub) begin
                        alu_op = alu_sub;
                    end
                end
                f3_slt: alu_op = alu_slt;
                f3_xor: alu_op = alu_xor;
                f3_or: alu_op = alu_or;
                f3_and: alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            op_load: wb_sel = wb_mem;
            op_jal: wb_sel = wb_pc;
            default: wb_sel = wb_alu;
        endcase
    end

    always_comb begin
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_sel_alu = 1'b0;
        en_write = 1'b0;
        pc_step = 1'b0;
        pc_branch = 1'b0;
        pc_jump = 1'b0;
        halt = 1'b0;
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: begin
                mem_read = 1'b1; // Address from PC
                state_next = st_decode;
            end
            st_decode: state_next = st_execute;
            st_execute: begin
                case (opcode)
                    op_rtype, op_itype, op_jal: state_next = st_writeback;
                    op_load, op_store: state_next = st_memory;
                    op_branch: begin
                        pc_branch = alu_zero;
                        pc_step = !alu_zero;
                        state_next = st_fetch;
                    end
                    op_system: begin
                        halt = 1'b1; // ECALL
                        state_next = st_idle;
                    end
                    default: begin
                        halt = 1'b1; // Unknown opcode also stops the core
                        state_next = st_idle;
                    end
                endcase
            end
            st_memory: begin
                mem_sel_alu = 1'b1;
                mem_read = (opcode == op_load);
                mem_write = (opcode == op_store);
                pc_step = (opcode == op_store);
                state_next = (opcode == op_store) ? st_fetch : st_writeback;
            end
            st_writeback: begin
                en_write = 1'b1;
                pc_jump = (opcode == op_jal);
                pc_step = (opcode != op_jal);
                state_next = st_fetch;
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= st_idle;
            running <= 1'b0;
            instr_q <= '0;
        end else begin
            state <= state_next;
            if (start) begin
                running <= 1'b1;
            end else if (halt) begin
                running <= 1'b0;
            end
            if (state == st_decode) begin
                instr_q <= mem_rdata; // Instruction latch
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/t08_program_counter.sv ====
`default_nettype none

module t08_program_counter (
    input  logic clk, nRst,
    input  logic start,
    input  logic pc_step, pc_branch, pc_jump,
    input  logic [t08_pkg::xlen-1:0] offset, // Already sign-extended
    output logic [t08_pkg::xlen-1:0] pc,
    output logic [t08_pkg::xlen-1:0] pc_next_seq
);
    import t08_pkg::*;

    assign pc_next_seq = pc + xlen'(4);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0; // Every run begins at address 0
        end else if (pc_step) begin
            pc <= pc_next_seq;
        end else if (pc_branch || pc_jump) begin
            pc <= pc + offset;
        end
    end

endmodule

`default_nettype wire

// ==== src/t08_alu.sv ====
`default_nettype none

module t08_alu (
    input  logic [t08_pkg::xlen-1:0] operand_a, operand_b,
    input  logic [2:0] alu_op,
    output logic [t08_pkg::xlen-1:0] alu_result,
    output logic zero
);
    import t08_pkg::*;

    logic [xlen-1:0] diff;

    assign diff = operand_a - operand_b;
    assign zero = (diff == '0); // Equal operands, used by BEQ

    always_comb begin
        case (alu_op)
            alu_add: alu_result = operand_a + operand_b;
            alu_sub: alu_result = diff;
            alu_and: alu_result = operand_a & operand_b;
            alu_or: alu_result = operand_a | operand_b;
            alu_xor: alu_result = operand_a ^ operand_b;
            alu_slt: alu_result = xlen'($signed(operand_a) < $signed(operand_b)); // Signed compare
            default: alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/t08_registers.sv ====
`default_nettype none

module t08_registers (
    input  logic clk, nRst,
    input  logic [4:0] address_r1, address_r2, address_rd,
    input  logic [t08_pkg::xlen-1:0] data_in_frommemory,
    input  logic [t08_pkg::xlen-1:0] data_in_frominstructionfetch,
    input  logic [t08_pkg::xlen-1:0] data_in_fromalu,
    input  logic [1:0] data_in_control, // Write-back source select
    input  logic en_read_1, en_read_2, en_write,
    output logic [t08_pkg::xlen-1:0] data_out_r1, data_out_r2
);
    import t08_pkg::*;

    logic [xlen-1:0] data [32];
    logic [xlen-1:0] data_in;

    always_comb begin
        case (data_in_control)
            wb_mem: data_in = data_in_frommemory;
            wb_pc: data_in = data_in_frominstructionfetch; // JAL link value
            wb_alu: data_in = data_in_fromalu;
            default: data_in = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            data_out_r1 <= '0;
            data_out_r2 <= '0;
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else begin
            if (en_read_1) begin
                data_out_r1 <= data[address_r1]; // Held while enable is low
            end
            if (en_read_2) begin
                data_out_r2 <= data[address_r2];
            end
            if (en_write && address_rd != 5'd0) begin // x0 stays zero
                data[address_rd] <= data_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/t08_pkg.sv ====
`default_nettype none

package t08_pkg;

    localparam int xlen = 32;
    localparam int mem_words = 256;

    // APB register map, memory words sit below addr_ctrl
    localparam logic [11:0] addr_ctrl = 12'h400;
    localparam logic [11:0] addr_status = 12'h404;

    localparam logic [6:0] op_rtype = 7'b0110011;
    localparam logic [6:0] op_itype = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [6:0] f7_sub = 7'b0100000;

    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;
    localparam logic [2:0] alu_slt = 3'd5;

    // Register file write-back sources
    localparam logic [1:0] wb_mem = 2'b00;
    localparam logic [1:0] wb_pc = 2'b01;
    localparam logic [1:0] wb_alu = 2'b10;

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_fetch = 3'd1;
    localparam logic [2:0] st_decode = 3'd2;
    localparam logic [2:0] st_execute = 3'd3;
    localparam logic [2:0] st_memory = 3'd4;
    localparam logic [2:0] st_writeback = 3'd5;

    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic imm20;
            logic [9:0] imm10_1;
            logic imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } t08_instr_t;

endpackage

`default_nettype wire
